/* source/gb_cart_pkg.sv */
// --------------------------------------------------------------------------
// Shared types and constants of the cartridge mapper
// Header offsets are byte addresses of 16-bit download words, the
// lower-address byte sits in data bits 7:0
// Bank widths cover MBC5 at most, so ROM up to 8 MB and RAM up to 128 KB
// --------------------------------------------------------------------------
package gb_cart_pkg;

	// Widths
	localparam int ROM_BANK_W = 9;		// ROM bank register and ROM mask
	localparam int RAM_BANK_W = 4;		// RAM bank register and RAM mask
	localparam int CRAM_AW    = 17;		// 128 KB cartridge RAM
	localparam int ROM_AW     = 23;		// 8 MB ROM byte address
	localparam int DL_AW      = 25;		// Download byte address

	// Header words in the ROM image
	localparam logic [DL_AW-1:0] HDR_TYPE_ADDR = 25'h146;	// High byte is cartridge type
	localparam logic [DL_AW-1:0] HDR_SIZE_ADDR = 25'h148;	// Low ROM size, high RAM size

	// CPU side constants
	localparam logic [3:0] RAM_EN_KEY   = 4'hA;			// Low nibble that unlocks RAM
	localparam logic [2:0] CRAM_BASE    = 3'b101;		// A000..BFFF window
	localparam logic [6:0] MBC2_RAM_TOP = 7'b1010000;	// A000..A1FF, 512 nibbles

	// --------------------------------------------------------------------------
	// Enums
	// --------------------------------------------------------------------------

	typedef enum logic [2:0] {
		MAP_NONE,				// 32 KB flat ROM
		MAP_MBC1,
		MAP_MBC2,
		MAP_MBC3,
		MAP_MBC5
	} mapper_e;

	// Write target from CPU address bits 15:13
	typedef enum logic [2:0] {
		REG_RAM_EN   = 3'd0,	// 0000..1FFF
		REG_ROM_BANK = 3'd1,	// 2000..3FFF
		REG_RAM_BANK = 3'd2,	// 4000..5FFF
		REG_MODE     = 3'd3		// 6000..7FFF
	} reg_region_e;

	// --------------------------------------------------------------------------
	// Buses
	// --------------------------------------------------------------------------

	typedef struct packed {
		logic             active;	// Cartridge image is being loaded
		logic             wr;		// One cycle word strobe
		logic [DL_AW-1:0] addr;		// Byte address of the word
		logic [15:0]      data;		// Lower-address byte in 7:0
	} dl_bus_t;

	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [15:0] addr;
		logic [7:0]  data;			// Write data from CPU
	} cpu_bus_t;

	typedef struct packed {
		mapper_e               mapper;
		logic [ROM_BANK_W-1:0] rom_mask;	// Mirrors banks beyond ROM size
		logic [RAM_BANK_W-1:0] ram_mask;
	} cart_info_t;

	typedef struct packed {
		logic [ROM_BANK_W-1:0] rom_bank;
		logic [RAM_BANK_W-1:0] ram_bank;
		logic                  mbc1_mode;	// 1 selects RAM banking on MBC1
		logic                  rtc_sel;		// MBC3 RTC register mapped at A000
		logic                  ram_en;
	} bank_state_t;

	typedef struct packed {
		logic               rd;
		logic               wr;
		logic [CRAM_AW-1:0] addr;
		logic [7:0]         data;
		logic               nibble;		// MBC2 access inside its 4-bit RAM
	} ram_req_t;

	// Register state after reset and during a download
	localparam bank_state_t BANKS_RST = '{rom_bank: 9'd1, default: '0};

endpackage

/* source/cart_header.sv */
// --------------------------------------------------------------------------
// Cartridge header capture and decode
// Bytes are only taken while a download is active, later writes to
// the same words overwrite earlier ones
// Unknown cartridge types fall back to a flat 32 KB ROM
// --------------------------------------------------------------------------
module cart_header import gb_cart_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  dl_bus_t    dl_i,
	output cart_info_t info_o
);

	logic [7:0] type_q;			// Byte 147h
	logic [7:0] rom_size_q;		// Byte 148h
	logic [7:0] ram_size_q;		// Byte 149h
	logic       hdr_wr;

	assign hdr_wr = dl_i.active & dl_i.wr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_q     <= 8'h00;
			rom_size_q <= 8'h00;
			ram_size_q <= 8'h00;
		end else if (hdr_wr) begin
			if (dl_i.addr == HDR_TYPE_ADDR)
				type_q <= dl_i.data[15:8];	// Odd byte of the word
			if (dl_i.addr == HDR_SIZE_ADDR) begin
				rom_size_q <= dl_i.data[7:0];
				ram_size_q <= dl_i.data[15:8];
			end
		end
	end

	// Mapper kind from the type byte
	always_comb begin
		if (type_q inside {[8'h01:8'h03]})
			info_o.mapper = MAP_MBC1;
		else if (type_q inside {[8'h05:8'h06]})
			info_o.mapper = MAP_MBC2;
		else if (type_q inside {[8'h0F:8'h13]})
			info_o.mapper = MAP_MBC3;
		else if (type_q inside {[8'h19:8'h1E]})
			info_o.mapper = MAP_MBC5;
		else
			info_o.mapper = MAP_NONE;	// ROM only and unsupported types
	end

	// Code n means 2^(n+1) banks of 16 KB
	always_comb begin
		if (rom_size_q <= 8'd8)
			info_o.rom_mask = 9'h1FF >> (4'd8 - rom_size_q[3:0]);
		else
			info_o.rom_mask = 9'h07F;	// Odd sizes like 52h..54h
	end

	// 2 KB and 8 KB carts have one bank
	always_comb begin
		case (ram_size_q)
			8'd1, 8'd2: info_o.ram_mask = 4'h0;
			8'd3:       info_o.ram_mask = 4'h3;	// 32 KB, four banks
			default:    info_o.ram_mask = 4'hF;	// 128 KB, also used when no RAM
		endcase
	end

endmodule

/* source/mbc_regs.sv */
// --------------------------------------------------------------------------
// MBC control registers written through the 0000..7FFF window
// Registers return to reset values during a download so a new image
// always starts at bank 1 with RAM locked
// Writes on MAP_NONE still update the registers but nothing reads them
// except the RAM enable
// --------------------------------------------------------------------------
module mbc_regs import gb_cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  dl_bus_t     dl_i,		// Only active is looked at
	input  cpu_bus_t    cpu_i,
	input  cart_info_t  info_i,
	output bank_state_t banks_o
);

	bank_state_t banks_q;
	reg_region_e region;
	logic        reg_wr;

	// Write strobe into the lower 32 KB
	assign reg_wr = cpu_i.wr & ~cpu_i.addr[15];
	assign region = reg_region_e'({1'b0, cpu_i.addr[14:13]});

	// --------------------------------------------------------------------------
	// Register file
	// --------------------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset || dl_i.active) begin
			banks_q <= BANKS_RST;
		end else if (reg_wr) begin
			case (region)
				REG_RAM_EN: begin
					banks_q.ram_en <= (cpu_i.data[3:0] == RAM_EN_KEY);	// Any other value locks
				end

				REG_ROM_BANK: begin
					if (info_i.mapper == MAP_MBC5) begin
						if (cpu_i.addr[13:12] == 2'b11)
							banks_q.rom_bank[8] <= cpu_i.data[0];		// 3000..3FFF
						else
							banks_q.rom_bank[7:0] <= cpu_i.data;		// 2000..2FFF, bank 0 allowed
					end else if (cpu_i.data[6:0] == 7'd0) begin
						banks_q.rom_bank <= 9'd1;		// Bank 0 maps to 1 on MBC1..3
					end else begin
						banks_q.rom_bank <= {2'b00, cpu_i.data[6:0]};
					end
				end

				REG_RAM_BANK: begin
					case (info_i.mapper)
						MAP_MBC3: begin
							if (cpu_i.data[3]) begin
								banks_q.rtc_sel <= 1'b1;	// 08h..0Ch select RTC
							end else begin
								banks_q.rtc_sel  <= 1'b0;
								banks_q.ram_bank <= {2'b00, cpu_i.data[1:0]};
							end
						end
						MAP_MBC5: banks_q.ram_bank <= cpu_i.data[3:0];	// Up to 16 banks
						default:  banks_q.ram_bank <= {2'b00, cpu_i.data[1:0]};
					endcase
				end

				REG_MODE: begin
					if (info_i.mapper == MAP_MBC1)
						banks_q.mbc1_mode <= cpu_i.data[0];
				end

				default: begin
					// Not reachable with bit 15 low
				end
			endcase
		end
	end

	assign banks_o = banks_q;

endmodule

/* source/mbc_addr_map.sv */
// --------------------------------------------------------------------------
// ROM and cartridge RAM address mapping, purely combinational
// rom_addr_o is only meaningful while rom_rd_o is high
// RAM requests are raised for the whole A000..BFFF window, enable and
// RTC rules are applied in the RAM block
// --------------------------------------------------------------------------
module mbc_addr_map import gb_cart_pkg::*; (
	input  cpu_bus_t          cpu_i,
	input  cart_info_t        info_i,
	input  bank_state_t       banks_i,
	output logic [ROM_AW-1:0] rom_addr_o,
	output logic              rom_rd_o,
	output ram_req_t          ram_req_o
);

	logic [ROM_BANK_W-1:0] rom_sel;		// Bank before masking
	logic [ROM_BANK_W-1:0] rom_field;
	logic [RAM_BANK_W-1:0] ram_sel;
	logic                  is_cram;

	// --------------------------------------------------------------------------
	// ROM side
	// --------------------------------------------------------------------------

	always_comb begin
		case (info_i.mapper)
			MAP_MBC1: begin
				if (banks_i.mbc1_mode)
					rom_sel = {4'b0000, banks_i.rom_bank[4:0]};
				else
					rom_sel = {2'b00, banks_i.ram_bank[1:0], banks_i.rom_bank[4:0]};	// Upper bits from RAM bank reg
			end
			MAP_MBC2, MAP_MBC3: rom_sel = {2'b00, banks_i.rom_bank[6:0]};
			default:            rom_sel = banks_i.rom_bank;		// MBC5 uses all 9 bits
		endcase
	end

	always_comb begin
		if (info_i.mapper == MAP_NONE)
			rom_field = {8'd0, cpu_i.addr[14]};	// Flat 32 KB
		else if (!cpu_i.addr[14])
			rom_field = '0;						// Fixed bank 0 at 0000..3FFF
		else
			rom_field = rom_sel & info_i.rom_mask;	// Mirror on small ROMs
	end

	assign rom_addr_o = {rom_field, cpu_i.addr[13:0]};
	assign rom_rd_o   = cpu_i.rd & ~cpu_i.addr[15];

	// --------------------------------------------------------------------------
	// RAM side
	// --------------------------------------------------------------------------

	always_comb begin
		case (info_i.mapper)
			MAP_MBC1: ram_sel = banks_i.mbc1_mode ? {2'b00, banks_i.ram_bank[1:0]} : 4'd0;
			MAP_MBC3: ram_sel = {2'b00, banks_i.ram_bank[1:0]};
			MAP_MBC5: ram_sel = banks_i.ram_bank;
			default:  ram_sel = 4'd0;		// MBC2 and flat carts have one bank
		endcase
	end

	assign is_cram = (cpu_i.addr[15:13] == CRAM_BASE);

	assign ram_req_o.rd     = cpu_i.rd & is_cram;
	assign ram_req_o.wr     = cpu_i.wr & is_cram;
	assign ram_req_o.addr   = {ram_sel & info_i.ram_mask, cpu_i.addr[12:0]};
	assign ram_req_o.data   = cpu_i.data;
	assign ram_req_o.nibble = (info_i.mapper == MAP_MBC2) &&
		(cpu_i.addr[15:9] == MBC2_RAM_TOP);		// Built-in 512x4 RAM

endmodule

/* source/cart_ram.sv */
// --------------------------------------------------------------------------
// Cartridge RAM, 128 KB byte wide, one port
// Read data arrives one cycle after the strobe together with ram_valid_o
// Writes while RAM is locked are dropped
// Contents are undefined after power up and are kept over reset
// --------------------------------------------------------------------------
module cart_ram import gb_cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  ram_req_t    ram_req_i,
	input  bank_state_t banks_i,	// ram_en and rtc_sel only
	output logic [7:0]  ram_data_o,
	output logic        ram_valid_o
);

	logic [7:0] mem [0:(1 << CRAM_AW) - 1];
	logic [7:0] rd_q;			// Raw array output
	logic       valid_q;
	logic       en_q;			// Qualifiers sampled with the read
	logic       rtc_q;
	logic       nibble_q;

	// Array port
	always_ff @(posedge clk_sys) begin
		if (ram_req_i.wr && banks_i.ram_en)
			mem[ram_req_i.addr] <= ram_req_i.data;
		if (ram_req_i.rd) begin
			rd_q     <= mem[ram_req_i.addr];
			en_q     <= banks_i.ram_en;
			rtc_q    <= banks_i.rtc_sel;
			nibble_q <= ram_req_i.nibble;
		end
	end

	// One cycle read valid
	always_ff @(posedge clk_sys) begin
		if (reset)
			valid_q <= 1'b0;
		else
			valid_q <= ram_req_i.rd;
	end

	// Output rules, first match wins
	always_comb begin
		if (!en_q)
			ram_data_o = 8'hFF;				// Locked RAM floats high
		else if (nibble_q)
			ram_data_o = {4'hF, rd_q[3:0]};	// MBC2 upper nibble open
		else if (rtc_q)
			ram_data_o = 8'h00;				// RTC registers not modelled
		else
			ram_data_o = rd_q;
	end

	assign ram_valid_o = valid_q;

endmodule

/* source/gb_cart_top.sv */
// --------------------------------------------------------------------------
// Cartridge mapper top level
// All CPU strobes are single clk_sys cycles, no back-pressure anywhere
// ROM data is fetched outside from rom_addr_o, RAM data comes back
// through ram_data_o one cycle after the read
// --------------------------------------------------------------------------
module gb_cart_top import gb_cart_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  dl_bus_t           dl_i,			// ROM image download
	input  cpu_bus_t          cpu_i,
	output logic [ROM_AW-1:0] rom_addr_o,
	output logic              rom_rd_o,
	output logic [7:0]        ram_data_o,
	output logic              ram_valid_o
);

	cart_info_t  info;			// Decoded header
	bank_state_t banks;			// MBC registers
	ram_req_t    ram_req;		// Mapped RAM access

	cart_header u_cart_header (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl_i    (dl_i),
		.info_o  (info)
	);

	mbc_regs u_mbc_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl_i    (dl_i),
		.cpu_i   (cpu_i),
		.info_i  (info),
		.banks_o (banks)
	);

	mbc_addr_map u_mbc_addr_map (
		.cpu_i      (cpu_i),
		.info_i     (info),
		.banks_i    (banks),
		.rom_addr_o (rom_addr_o),
		.rom_rd_o   (rom_rd_o),
		.ram_req_o  (ram_req)
	);

	cart_ram u_cart_ram (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ram_req_i   (ram_req),
		.banks_i     (banks),
		.ram_data_o  (ram_data_o),
		.ram_valid_o (ram_valid_o)
	);

endmodule

/* test/gb_cart_asserts.sv */
// --------------------------------------------------------------------------
// Port level assertions for the cartridge mapper, bound into gb_cart_top
// fail_cnt counts failed assertions for the testbench summary
// --------------------------------------------------------------------------
module gb_cart_asserts import gb_cart_pkg::*; (
	input logic     clk_sys,
	input logic     reset,
	input cpu_bus_t cpu_i,
	input logic     rom_rd_o,
	input logic     ram_valid_o
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_cnt;

	initial fail_cnt = 0;

	// ROM reads only from the lower 32 KB
	a_rom_rd_low: assert property (@(posedge clk_sys) disable iff (reset)
		rom_rd_o |-> !cpu_i.addr[15])
	else begin
		$error("rom_rd_o high with CPU address bit 15 set");
		fail_cnt++;
	end

	a_ram_valid_next: assert property (@(posedge clk_sys) disable iff (reset)
		(cpu_i.rd && cpu_i.addr[15:13] == CRAM_BASE) |=> ram_valid_o)
	else begin
		$error("ram_valid_o missing one cycle after cartridge RAM read");
		fail_cnt++;
	end

	a_valid_reset: assert property (@(posedge clk_sys) reset |=> !ram_valid_o)
	else begin
		$error("ram_valid_o high after a reset cycle");
		fail_cnt++;
	end

endmodule

bind gb_cart_top gb_cart_asserts u_asserts (.*);

/* test/gb_cart_tb.sv */
// --------------------------------------------------------------------------
// Testbench for the cartridge mapper top level
// CPU and download strobes last one clk_sys cycle
// Outputs are sampled at the falling edge where they are stable
// Reference model keeps its own header bytes, bank registers and RAM copy
// Only RAM bytes written earlier in a test are read back
// --------------------------------------------------------------------------
module gb_cart_tb import gb_cart_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_NS          = 8;
	localparam int N_TESTS         = 5;
	localparam int MAX_TEST_CYCLES = 400;	// Longest test with margin
	localparam cpu_bus_t CPU_IDLE  = '0;

	logic              clk_sys;
	logic              reset;
	dl_bus_t           dl;
	cpu_bus_t          cpu;
	logic [ROM_AW-1:0] rom_addr;
	logic              rom_rd;
	logic [7:0]        ram_data;
	logic              ram_valid;

	// Reference state
	logic [7:0]            ref_type, ref_rom_size, ref_ram_size;
	logic [ROM_BANK_W-1:0] ref_rom_bank;
	logic [RAM_BANK_W-1:0] ref_ram_bank;
	logic                  ref_mode, ref_rtc, ref_ram_en;
	logic [7:0]            ref_mem [0:(1 << CRAM_AW) - 1];

	logic [ROM_AW-1:0] exp_rom[$];		// Expected results in issue order
	logic [7:0]        exp_ram[$];
	logic [31:0]       seed = 32'he763_7ddf;
	int                errors, test_base, n_checks, n_tests, ram_seen;

	gb_cart_top dut0 (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_i        (dl),
		.cpu_i       (cpu),
		.rom_addr_o  (rom_addr),
		.rom_rd_o    (rom_rd),
		.ram_data_o  (ram_data),
		.ram_valid_o (ram_valid)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_NS / 2) clk_sys = ~clk_sys;
	end

	// Watchdog at twice the worst case run length
	initial begin
		#(N_TESTS * MAX_TEST_CYCLES * CLK_NS * 2);
		$display("watchdog timeout, tests did not complete in time");
		$display("Finished with errors");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;	// LCG step
		return seed;
	endfunction

	// --------------------------------------------------------------------------
	// Reference model
	// --------------------------------------------------------------------------

	function automatic mapper_e ref_mapper();
		if (ref_type >= 8'h01 && ref_type <= 8'h03) return MAP_MBC1;
		if (ref_type == 8'h05 || ref_type == 8'h06) return MAP_MBC2;
		if (ref_type >= 8'h0F && ref_type <= 8'h13) return MAP_MBC3;
		if (ref_type >= 8'h19 && ref_type <= 8'h1E) return MAP_MBC5;
		return MAP_NONE;
	endfunction

	function automatic logic [ROM_BANK_W-1:0] ref_rom_mask();
		logic [9:0] m;
		m = (10'd2 << ref_rom_size[3:0]) - 10'd1;	// n+1 low ones
		return (ref_rom_size > 8'd8) ? 9'h07F : m[8:0];
	endfunction

	function automatic logic [RAM_BANK_W-1:0] ref_ram_mask();
		if (ref_ram_size == 8'd1 || ref_ram_size == 8'd2) return 4'h0;
		return (ref_ram_size == 8'd3) ? 4'h3 : 4'hF;
	endfunction

	function automatic logic [ROM_AW-1:0] ref_rom_addr(input logic [15:0] a);
		logic [ROM_BANK_W-1:0] bank;
		if (ref_mapper() == MAP_NONE)
			return {8'd0, a[14:0]};			// Flat 32 KB
		bank = '0;
		if (a[14]) begin
			case (ref_mapper())
				MAP_MBC1: bank = ref_mode ? ref_rom_bank[4:0]
					: {ref_ram_bank[1:0], ref_rom_bank[4:0]};
				MAP_MBC5: bank = ref_rom_bank;
				default:  bank = ref_rom_bank[6:0];
			endcase
			bank = bank & ref_rom_mask();
		end
		return {bank, a[13:0]};
	endfunction

	function automatic logic [CRAM_AW-1:0] ref_ram_index(input logic [15:0] a);
		logic [RAM_BANK_W-1:0] b;
		case (ref_mapper())
			MAP_MBC1: b = ref_mode ? ref_ram_bank[1:0] : 4'd0;
			MAP_MBC3: b = ref_ram_bank[1:0];
			MAP_MBC5: b = ref_ram_bank;
			default:  b = 4'd0;
		endcase
		return {b & ref_ram_mask(), a[12:0]};
	endfunction

	function automatic logic [7:0] ref_ram_data(input logic [15:0] a);
		if (!ref_ram_en) return 8'hFF;
		if (ref_mapper() == MAP_MBC2 && a[15:9] == 7'h50)
			return {4'hF, ref_mem[ref_ram_index(a)][3:0]};
		if (ref_rtc) return 8'h00;
		return ref_mem[ref_ram_index(a)];
	endfunction

	// Register and RAM effect of one CPU write
	function automatic void ref_write(input logic [15:0] a, input logic [7:0] d);
		if (a[15:13] == 3'b101 && ref_ram_en)
			ref_mem[ref_ram_index(a)] = d;
		if (!a[15]) begin
			case (a[14:13])
				2'd0: ref_ram_en = (d[3:0] == 4'hA);
				2'd1: begin
					if (ref_mapper() == MAP_MBC5 && a[12]) ref_rom_bank[8] = d[0];
					else if (ref_mapper() == MAP_MBC5) ref_rom_bank[7:0] = d;
					else ref_rom_bank = (d[6:0] == 7'd0) ? 9'd1 : {2'b00, d[6:0]};
				end
				2'd2: begin
					if (ref_mapper() == MAP_MBC3 && d[3]) ref_rtc = 1'b1;
					else if (ref_mapper() == MAP_MBC5) ref_ram_bank = d[3:0];
					else begin
						ref_rtc      = 1'b0;		// Only MBC3 ever sets it
						ref_ram_bank = {2'b00, d[1:0]};
					end
				end
				default: if (ref_mapper() == MAP_MBC1) ref_mode = d[0];
			endcase
		end
	endfunction

	function automatic void ref_reset_regs();
		ref_rom_bank = 9'd1;
		ref_ram_bank = '0;
		{ref_mode, ref_rtc, ref_ram_en} = 3'b000;
	endfunction

	// --------------------------------------------------------------------------
	// Checks
	// --------------------------------------------------------------------------

	task automatic check_rom_addr(input logic [ROM_AW-1:0] got,
			input logic [ROM_AW-1:0] exp);
		n_checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch rom_addr_o got %h expected %h", got, exp);
		end
	endtask

	task automatic check_ram_data(input logic [7:0] got, input logic [7:0] exp);
		n_checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch ram_data_o got %h expected %h", got, exp);
		end
	endtask

	// Compare process sampling at the falling edge where outputs have settled
	always @(negedge clk_sys) begin
		if (rom_rd === 1'b1) begin
			if (exp_rom.size() == 0) begin
				errors++;
				$display("rom_rd_o went high with no ROM read issued");
			end else
				check_rom_addr(rom_addr, exp_rom.pop_front());
		end
		if (ram_valid === 1'b1) begin
			ram_seen++;
			if (exp_ram.size() == 0) begin
				errors++;
				$display("ram_valid_o went high with no RAM read issued");
			end else
				check_ram_data(ram_data, exp_ram.pop_front());
		end
	end

	// --------------------------------------------------------------------------
	// Stimulus tasks
	// --------------------------------------------------------------------------

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		cpu <= '{rd: 1'b0, wr: 1'b1, addr: a, data: d};
		ref_write(a, d);
		@(posedge clk_sys);
		cpu <= CPU_IDLE;
	endtask

	task automatic rom_read(input logic [15:0] a);
		@(posedge clk_sys);
		cpu <= '{rd: 1'b1, wr: 1'b0, addr: a, data: 8'h00};
		exp_rom.push_back(ref_rom_addr(a));
		@(posedge clk_sys);
		cpu <= CPU_IDLE;
	endtask

	task automatic ram_read(input logic [15:0] a);
		int seen;
		@(posedge clk_sys);
		cpu <= '{rd: 1'b1, wr: 1'b0, addr: a, data: 8'h00};
		exp_ram.push_back(ref_ram_data(a));
		seen = ram_seen;
		@(posedge clk_sys);
		cpu <= CPU_IDLE;
		for (int i = 0; i < 4 && ram_seen == seen; i++)
			@(posedge clk_sys);
		if (ram_seen == seen) begin
			errors++;
			$display("ram_valid_o never came after RAM read at %h", a);
			void'(exp_ram.pop_front());
		end
	endtask

	// Header words go in during an active download while registers stay reset
	task automatic load_header(input logic [7:0] t, input logic [7:0] rs,
			input logic [7:0] ms);
		@(posedge clk_sys);
		dl <= '{active: 1'b1, wr: 1'b1, addr: HDR_TYPE_ADDR, data: {t, 8'h00}};
		@(posedge clk_sys);
		dl <= '{active: 1'b1, wr: 1'b1, addr: HDR_SIZE_ADDR, data: {ms, rs}};
		@(posedge clk_sys);
		dl <= '0;
		{ref_type, ref_rom_size, ref_ram_size} = {t, rs, ms};
		ref_reset_regs();
	endtask

	task automatic end_test(input string name);
		if (exp_rom.size() != 0 || exp_ram.size() != 0) begin
			errors++;
			$display("%s left reads that the DUT never answered", name);
			exp_rom.delete();
			exp_ram.delete();
		end
		n_tests++;
		$display("test %s done, %0d errors", name, errors - test_base);
		test_base = errors;
	endtask

	// --------------------------------------------------------------------------
	// Test sequence
	// --------------------------------------------------------------------------

	initial begin
		logic [31:0] r;
		logic [15:0] addr_list [8];
		logic [3:0]  bank_list [8];
		int          total;
		{errors, test_base, n_checks, n_tests, ram_seen} = '0;
		{ref_type, ref_rom_size, ref_ram_size} = '0;
		ref_reset_regs();
		reset <= 1'b1;
		dl    <= '0;
		cpu   <= CPU_IDLE;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;

		// Flat ROM with RAM locked
		rom_read(16'h0000);
		rom_read(16'h3FFF);
		rom_read(16'h4000);
		rom_read(16'h7FFF);
		for (int i = 0; i < 4; i++) begin
			r = next_rand();
			rom_read({1'b0, r[14:0]});
		end
		ram_read(16'hA000);
		ram_read(16'hBFFF);
		end_test("reset_state");

		load_header(8'h01, 8'h04, 8'h03);	// MBC1 with 32 banks
		cpu_write(16'h2000, 8'h00);
		rom_read(16'h4000);					// Bank 0 reads as 1
		cpu_write(16'h4000, 8'h03);			// Upper bits must fall to rom_mask
		for (int i = 0; i < 4; i++) begin
			r = next_rand();
			cpu_write(16'h2000, r[7:0]);
			rom_read({2'b01, r[21:8]});
		end
		load_header(8'h01, 8'h06, 8'h03);	// 128 banks so upper bits survive the mask
		cpu_write(16'h2000, 8'h05);
		cpu_write(16'h4000, 8'h02);
		rom_read(16'h4100);
		cpu_write(16'h6000, 8'h01);			// Mode 1 drops them again
		rom_read(16'h4100);
		rom_read(16'h0100);
		end_test("mbc1");

		load_header(8'h19, 8'h08, 8'h00);	// MBC5 with 512 banks
		cpu_write(16'h3000, 8'h01);
		cpu_write(16'h2000, 8'h23);
		rom_read(16'h6ABC);
		for (int i = 0; i < 4; i++) begin
			r = next_rand();
			cpu_write(16'h3000, {7'd0, r[8]});
			cpu_write(16'h2000, r[7:0]);
			rom_read({2'b01, r[29:16]});
		end
		cpu_write(16'h3000, 8'h00);
		cpu_write(16'h2000, 8'h00);
		rom_read(16'h4000);					// Bank 0 is legal here
		end_test("mbc5");

		load_header(8'h1B, 8'h02, 8'h03);	// MBC5 with four RAM banks
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'h4000, 8'h00);
		cpu_write(16'hA123, 8'h5A);
		cpu_write(16'h0000, 8'h00);			// Lock
		ram_read(16'hA123);
		cpu_write(16'hA123, 8'hA5);			// Must be dropped
		cpu_write(16'h0000, 8'h0A);
		ram_read(16'hA123);
		for (int i = 0; i < 8; i++) begin
			r = next_rand();
			bank_list[i] = r[3:0];
			addr_list[i] = {3'b101, r[16:4]};
			cpu_write(16'h4000, {4'h0, r[3:0]});
			cpu_write(addr_list[i], r[31:24]);
		end
		for (int i = 0; i < 8; i++) begin
			cpu_write(16'h4000, {4'h0, bank_list[i] ^ 4'hC});	// Same bank through ram_mask
			ram_read(addr_list[i]);
		end
		end_test("ram_banking");

		load_header(8'h05, 8'h00, 8'h00);	// MBC2 nibble RAM
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'hA010, 8'h3C);
		ram_read(16'hA010);
		cpu_write(16'hA210, 8'h3C);			// Outside the nibble window
		ram_read(16'hA210);
		load_header(8'h11, 8'h00, 8'h03);	// MBC3
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'h4000, 8'h01);
		cpu_write(16'hA050, 8'h77);
		cpu_write(16'h4000, 8'h08);			// RTC select
		ram_read(16'hA050);
		cpu_write(16'h4000, 8'h01);
		ram_read(16'hA050);
		end_test("read_rules");

		repeat (2) @(posedge clk_sys);
		total = errors + dut0.u_asserts.fail_cnt;
		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, total);
		if (total == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* gb_cart_top.f */
source/gb_cart_pkg.sv
source/cart_header.sv
source/mbc_regs.sv
source/mbc_addr_map.sv
source/cart_ram.sv
source/gb_cart_top.sv
test/gb_cart_asserts.sv
test/gb_cart_tb.sv

/* Bender.yml */
package:
  name: gb_cart

sources:
  - source/gb_cart_pkg.sv
  - source/cart_header.sv
  - source/mbc_regs.sv
  - source/mbc_addr_map.sv
  - source/cart_ram.sv
  - source/gb_cart_top.sv
  - target: test
    files:
      - test/gb_cart_asserts.sv
      - test/gb_cart_tb.sv
